// ==== alloc_pkg.sv ====
// shared pool constants and types; pool size and pipe depth are fixed, the event ptr stays 32 bits wide.
`default_nettype none

package alloc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pool and datapath sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int NUM_PTRS    = 16;  // buffers in the pool.
    localparam int PTR_W       = 4;   // index width into the pool.
    localparam int PTR_BITS    = 32;  // pointer field of requests and events.
    localparam int PIPE_STAGES = 2;   // sampling register plus fanout-one register.
    localparam int CNT_W       = 16;  // statistics counter width.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request, event, grant and statistics records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic                alloc;    // single-cycle strobe.
        logic                dealloc;  // single-cycle strobe.
        logic [PTR_BITS-1:0] ptr;      // pointer to give back.
    } alloc_req_t;

    typedef struct packed {
        logic                alloc;
        logic                alloc_fail;  // pool empty.
        logic                alloc_err;   // not ready, or lost to a dealloc.
        logic                dealloc;
        logic                dealloc_fail;  // pointer out of range.
        logic                dealloc_err;   // not ready, or double free.
        logic [PTR_BITS-1:0] ptr;
    } alloc_mon_t;

    typedef struct packed {
        logic                valid;
        logic [PTR_BITS-1:0] ptr;
    } alloc_grant_t;

    typedef struct packed {
        logic [CNT_W-1:0] alloc_cnt;
        logic [CNT_W-1:0] alloc_fail_cnt;
        logic [CNT_W-1:0] alloc_err_cnt;
        logic [CNT_W-1:0] dealloc_cnt;
        logic [CNT_W-1:0] dealloc_fail_cnt;
        logic [CNT_W-1:0] dealloc_err_cnt;
    } alloc_stats_t;

    // Controller states. ST_READY is only left through reset.
    typedef enum logic [0:0] {
        ST_INIT  = 1'b0,
        ST_READY = 1'b1
    } fsm_state_t;

endpackage : alloc_pkg

`default_nettype wire

// ==== alloc_ctrl_fsm.sv ====
// init sweep takes exactly NUM_PTRS cycles after rst falls; ready then stays high until the next rst.
`default_nettype none
`timescale 1ns/100ps

module alloc_ctrl_fsm (
    input  logic                        from_tx,
    input  logic                        rst,
    output logic                        ready,
    output logic                        init_en,
    output logic [alloc_pkg::PTR_W-1:0] init_idx
);
    import alloc_pkg::*;

    fsm_state_t       state_q;
    fsm_state_t       state_d;
    logic [PTR_W-1:0] idx_q;
    logic [PTR_W-1:0] idx_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_d = state_q;
        idx_d   = idx_q;
        case (state_q)
            ST_INIT: begin
                idx_d = idx_q + PTR_W'(1);  // wraps to zero after the last entry.
                if (idx_q == PTR_W'(NUM_PTRS - 1)) begin
                    state_d = ST_READY;
                end
            end
            ST_READY: begin
                idx_d = idx_q;  // sweep is done, index parks.
            end
            default: begin
                state_d = ST_INIT;
                idx_d   = '0;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge from_tx) begin
        if (rst) begin
            state_q <= ST_INIT;
            idx_q   <= '0;
        end else begin
            state_q <= state_d;
            idx_q   <= idx_d;
        end
    end

    assign ready    = (state_q == ST_READY);
    assign init_en  = (state_q == ST_INIT);  // one entry is cleared per cycle.
    assign init_idx = idx_q;

endmodule : alloc_ctrl_fsm

`default_nettype wire

// ==== ptr_free_list.sv ====
// one request per cycle at most; requests are seen one cycle after sampling, dealloc wins a collision.
`default_nettype none
`timescale 1ns/100ps

module ptr_free_list (
    input  logic                        from_tx,
    input  logic                        rst,
    input  alloc_pkg::alloc_req_t       req,
    input  logic                        ready,
    input  logic                        init_en,
    input  logic [alloc_pkg::PTR_W-1:0] init_idx,
    output alloc_pkg::alloc_mon_t       mon_raw,
    output alloc_pkg::alloc_grant_t     grant_raw
);
    import alloc_pkg::*;

    alloc_req_t          req_q;
    logic                rdy_q;
    logic [NUM_PTRS-1:0] in_use;  // set bit means the pointer is handed out.
    logic                found;
    logic [PTR_W-1:0]    free_idx;
    logic [PTR_W-1:0]    dealloc_idx;
    logic                set_en;
    logic                clr_en;
    alloc_mon_t          ev;
    alloc_grant_t        gnt;

    // request and ready are sampled together.
    always_ff @(posedge from_tx) begin
        if (rst) begin
            req_q <= '0;
            rdy_q <= 1'b0;
        end else begin
            req_q <= req;
            rdy_q <= ready;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lowest free entry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        found    = 1'b0;
        free_idx = '0;
        for (int i = NUM_PTRS - 1; i >= 0; i--) begin
            if (!in_use[i]) begin
                found    = 1'b1;
                free_idx = PTR_W'(i);  // last hit is the lowest index.
            end
        end
    end

    assign dealloc_idx = req_q.ptr[PTR_W-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // classification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        ev     = '0;
        gnt    = '0;
        set_en = 1'b0;
        clr_en = 1'b0;
        if (req_q.dealloc) begin
            ev.ptr = req_q.ptr;  // dealloc events echo the requested pointer.
            if (!rdy_q) begin
                ev.dealloc_err = 1'b1;
            end else if (req_q.ptr >= PTR_BITS'(NUM_PTRS)) begin
                ev.dealloc_fail = 1'b1;
            end else if (!in_use[dealloc_idx]) begin
                ev.dealloc_err = 1'b1;  // double free.
            end else begin
                ev.dealloc = 1'b1;
                clr_en     = 1'b1;
            end
            ev.alloc_err = req_q.alloc;  // a colliding alloc is refused.
        end else if (req_q.alloc) begin
            if (!rdy_q) begin
                ev.alloc_err = 1'b1;
            end else if (!found) begin
                ev.alloc_fail = 1'b1;
            end else begin
                ev.alloc  = 1'b1;
                ev.ptr    = PTR_BITS'(free_idx);
                gnt.valid = 1'b1;
                gnt.ptr   = PTR_BITS'(free_idx);
                set_en    = 1'b1;
            end
        end
    end

    // cleared one entry per cycle by the init sweep.
    always_ff @(posedge from_tx) begin
        if (init_en) begin
            in_use[init_idx] <= 1'b0;
        end
        if (clr_en) begin
            in_use[dealloc_idx] <= 1'b0;
        end
        if (set_en) begin
            in_use[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge from_tx) begin
        if (rst) begin
            mon_raw   <= '0;
            grant_raw <= '0;
        end else begin
            mon_raw   <= ev;
            grant_raw <= gnt;
        end
    end

endmodule : ptr_free_list

`default_nettype wire

// ==== event_pipe.sv ====
// fixed PIPE_STAGES latency with no enable or stall; every stage clears to zero on rst.
`default_nettype none
`timescale 1ns/100ps

module event_pipe #(
    parameter type T = logic
) (
    input  logic from_tx,
    input  logic rst,
    input  T     d,
    output T     q
);
    import alloc_pkg::*;

    // stage 0 samples, the last stage only feeds q.
    T stage_q [PIPE_STAGES];

    always_ff @(posedge from_tx) begin
        if (rst) begin
            for (int i = 0; i < PIPE_STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= d;
            for (int i = 1; i < PIPE_STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign q = stage_q[PIPE_STAGES-1];

endmodule : event_pipe

`default_nettype wire

// ==== mon_counters.sv ====
// counters saturate at all ones and are cleared only by rst; there is no readout or clear port.
`default_nettype none
`timescale 1ns/100ps

module mon_counters (
    input  logic                    from_tx,
    input  logic                    rst,
    input  alloc_pkg::alloc_mon_t   mon,
    output alloc_pkg::alloc_stats_t stats
);
    import alloc_pkg::*;

    alloc_stats_t cnt_q;
    alloc_stats_t cnt_d;

    // add one unless already at the top.
    function automatic logic [CNT_W-1:0] sat_inc(
        input logic [CNT_W-1:0] cnt,
        input logic             hit
    );
        logic [CNT_W-1:0] res;
        res = cnt;
        if (hit && (cnt != '1)) begin
            res = cnt + CNT_W'(1);
        end
        return res;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one counter per event bit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        cnt_d.alloc_cnt        = sat_inc(cnt_q.alloc_cnt, mon.alloc);
        cnt_d.alloc_fail_cnt   = sat_inc(cnt_q.alloc_fail_cnt, mon.alloc_fail);
        cnt_d.alloc_err_cnt    = sat_inc(cnt_q.alloc_err_cnt, mon.alloc_err);
        cnt_d.dealloc_cnt      = sat_inc(cnt_q.dealloc_cnt, mon.dealloc);
        cnt_d.dealloc_fail_cnt = sat_inc(cnt_q.dealloc_fail_cnt, mon.dealloc_fail);
        cnt_d.dealloc_err_cnt  = sat_inc(cnt_q.dealloc_err_cnt, mon.dealloc_err);
    end

    always_ff @(posedge from_tx) begin
        if (rst) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;  // visible one cycle after the event.
        end
    end

    assign stats = cnt_q;

endmodule : mon_counters

`default_nettype wire

// ==== alloc_mon_top.sv ====
// single requester, no back-pressure; mon and grant trail the sampling edge by 3 cycles.
`default_nettype none
`timescale 1ns/100ps

module alloc_mon_top (
    input  logic                    from_tx,
    input  logic                    rst,
    input  alloc_pkg::alloc_req_t   req,
    output logic                    ready,
    output alloc_pkg::alloc_grant_t grant,
    output alloc_pkg::alloc_mon_t   mon,
    output alloc_pkg::alloc_stats_t stats
);
    import alloc_pkg::*;

    logic             init_en;
    logic [PTR_W-1:0] init_idx;
    alloc_mon_t       mon_raw;
    alloc_grant_t     grant_raw;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control and free map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    alloc_ctrl_fsm i_alloc_ctrl_fsm (
        .from_tx  (from_tx),
        .rst      (rst),
        .ready    (ready),
        .init_en  (init_en),
        .init_idx (init_idx)
    );

    ptr_free_list i_ptr_free_list (
        .from_tx   (from_tx),
        .rst       (rst),
        .req       (req),
        .ready     (ready),
        .init_en   (init_en),
        .init_idx  (init_idx),
        .mon_raw   (mon_raw),
        .grant_raw (grant_raw)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output pipes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    event_pipe #(
        .T (alloc_mon_t)
    ) i_mon_pipe (
        .from_tx (from_tx),
        .rst     (rst),
        .d       (mon_raw),
        .q       (mon)
    );

    event_pipe #(
        .T (alloc_grant_t)
    ) i_grant_pipe (
        .from_tx (from_tx),
        .rst     (rst),
        .d       (grant_raw),
        .q       (grant)
    );

    // counts what leaves the monitor pipe.
    mon_counters i_mon_counters (
        .from_tx (from_tx),
        .rst     (rst),
        .mon     (mon),
        .stats   (stats)
    );

endmodule : alloc_mon_top

`default_nettype wire

// ==== alloc_mon_checker.sv ====
// bound into alloc_mon_top; every property is ignored while rst is high.
`default_nettype none
`timescale 1ns/100ps

module alloc_mon_checker (
    input logic                    from_tx,
    input logic                    rst,
    input logic                    ready,
    input alloc_pkg::alloc_grant_t grant,
    input alloc_pkg::alloc_mon_t   mon,
    input alloc_pkg::alloc_stats_t stats
);
    import alloc_pkg::*;

    int unsigned n_excl  = 0;
    int unsigned n_grant = 0;
    int unsigned n_ready = 0;
    int unsigned n_cnt   = 0;
    int unsigned fails;

    assign fails = n_excl + n_grant + n_ready + n_cnt;  // read by the testbench top.

    // true when no counter went down.
    function automatic logic held(input alloc_stats_t now, input alloc_stats_t was);
        return (now.alloc_cnt >= was.alloc_cnt) && (now.alloc_fail_cnt >= was.alloc_fail_cnt)
            && (now.alloc_err_cnt >= was.alloc_err_cnt) && (now.dealloc_cnt >= was.dealloc_cnt)
            && (now.dealloc_fail_cnt >= was.dealloc_fail_cnt)
            && (now.dealloc_err_cnt >= was.dealloc_err_cnt);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // event and counter properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    excl_a: assert property (@(posedge from_tx) disable iff (rst)
        $onehot0({mon.alloc, mon.alloc_fail, mon.dealloc_fail}))
    else begin
        n_excl++;
        $error("more than one of alloc, alloc_fail and dealloc_fail in one event");
    end

    grant_a: assert property (@(posedge from_tx) disable iff (rst)
        grant.valid == mon.alloc)
    else begin
        n_grant++;
        $error("grant valid and mon alloc disagree");
    end

    ready_a: assert property (@(posedge from_tx) disable iff (rst)
        $fell(ready) |-> $past(rst))
    else begin
        n_ready++;
        $error("ready fell without reset");
    end

    cnt_a: assert property (@(posedge from_tx) disable iff (rst)
        !$past(rst) |-> held(stats, $past(stats)))
    else begin
        n_cnt++;
        $error("a statistics counter decreased without reset");
    end

endmodule : alloc_mon_checker

bind alloc_mon_top alloc_mon_checker i_alloc_mon_checker (
    .from_tx (from_tx),
    .rst     (rst),
    .ready   (ready),
    .grant   (grant),
    .mon     (mon),
    .stats   (stats)
);

`default_nettype wire

// ==== alloc_mon_check.sv ====
// req and ready are taken at the rising edge; mon and grant are compared 3 cycles after that edge.
`default_nettype none
`timescale 1ns/100ps

module alloc_mon_check (
    input  logic                    from_tx,
    input  logic                    rst,
    input  alloc_pkg::alloc_req_t   req,
    input  logic                    ready,
    input  alloc_pkg::alloc_grant_t grant,
    input  alloc_pkg::alloc_mon_t   mon,
    input  alloc_pkg::alloc_stats_t stats,
    input  int                      test_id,
    input  logic                    test_done,
    input  logic                    all_done,
    output int                      err_total
);
    import alloc_pkg::*;

    localparam int LAT = 3;  // sampling edge to mon.

    logic [NUM_PTRS-1:0] used_model;  // set bit means handed out.
    alloc_mon_t          exp_q[$];
    alloc_mon_t          exp_ev;
    alloc_grant_t        exp_gnt;
    alloc_stats_t        exp_stats;
    logic                rdy_exp;
    int                  init_cnt  = 0;
    int                  errors    = 0;
    int                  test_errs = 0;
    int                  tests_run = 0;
    int                  tests_bad = 0;

    assign err_total = errors;

    function automatic string test_name(input int id);
        case (id)
            1: return "init";
            2: return "seq_alloc";
            3: return "exhaust";
            4: return "free_reuse";
            5: return "bad_dealloc";
            6: return "random_mix";
            default: return "unknown";
        endcase
    endfunction

    function automatic logic [CNT_W-1:0] bump(input logic [CNT_W-1:0] c, input logic hit);
        return (hit && c != '1) ? c + CNT_W'(1) : c;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model of one request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic alloc_mon_t predict(input alloc_req_t r, input logic rdy);
        alloc_mon_t       e;
        logic             hit;
        logic [PTR_W-1:0] low;
        e   = '0;
        hit = 1'b0;
        low = '0;
        for (int i = 0; i < NUM_PTRS; i++) begin
            if (!hit && !used_model[PTR_W'(i)]) begin
                hit = 1'b1;
                low = PTR_W'(i);
            end
        end
        if (r.dealloc) begin
            e.ptr       = r.ptr;
            e.alloc_err = r.alloc;  // the alloc loses the collision.
            if (!rdy) begin
                e.dealloc_err = 1'b1;
            end else if (r.ptr >= PTR_BITS'(NUM_PTRS)) begin
                e.dealloc_fail = 1'b1;
            end else if (!used_model[r.ptr[PTR_W-1:0]]) begin
                e.dealloc_err = 1'b1;  // double free.
            end else begin
                e.dealloc                    = 1'b1;
                used_model[r.ptr[PTR_W-1:0]] = 1'b0;
            end
        end else if (r.alloc) begin
            if (!rdy) begin
                e.alloc_err = 1'b1;
            end else if (!hit) begin
                e.alloc_fail = 1'b1;
            end else begin
                e.alloc         = 1'b1;
                e.ptr           = PTR_BITS'(low);
                used_model[low] = 1'b1;
            end
        end
        return e;
    endfunction

    task automatic note_error();
        errors    = errors + 1;
        test_errs = test_errs + 1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare process
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge from_tx) begin
        if (rst) begin
            exp_q.delete();
            repeat (LAT + 1) begin
                exp_q.push_back(alloc_mon_t'(0));  // pipe stages hold zeros after reset.
            end
            used_model = '0;  // the init sweep frees every entry.
            exp_stats  = '0;
            init_cnt   = 0;
        end else begin
            rdy_exp = (init_cnt >= NUM_PTRS);
            if (ready !== rdy_exp) begin
                $display("[ERROR] %s ready: expected %0d, actual %0d",
                         test_name(test_id), rdy_exp, ready);
                note_error();
            end
            if (stats !== exp_stats) begin
                $display("[ERROR] %s stats: expected %h, actual %h",
                         test_name(test_id), exp_stats, stats);
                note_error();
            end
            if (exp_q.size() > LAT) begin
                exp_ev        = exp_q.pop_front();
                exp_gnt.valid = exp_ev.alloc;
                exp_gnt.ptr   = exp_ev.alloc ? exp_ev.ptr : '0;
                if (mon !== exp_ev) begin
                    $display("[ERROR] %s mon: expected %h, actual %h",
                             test_name(test_id), exp_ev, mon);
                    note_error();
                end
                if (grant !== exp_gnt) begin
                    $display("[ERROR] %s grant: expected %h, actual %h",
                             test_name(test_id), exp_gnt, grant);
                    note_error();
                end
                exp_stats.alloc_cnt        = bump(exp_stats.alloc_cnt, exp_ev.alloc);
                exp_stats.alloc_fail_cnt   = bump(exp_stats.alloc_fail_cnt, exp_ev.alloc_fail);
                exp_stats.alloc_err_cnt    = bump(exp_stats.alloc_err_cnt, exp_ev.alloc_err);
                exp_stats.dealloc_cnt      = bump(exp_stats.dealloc_cnt, exp_ev.dealloc);
                exp_stats.dealloc_fail_cnt = bump(exp_stats.dealloc_fail_cnt,
                                                  exp_ev.dealloc_fail);
                exp_stats.dealloc_err_cnt  = bump(exp_stats.dealloc_err_cnt,
                                                  exp_ev.dealloc_err);
            end
            exp_q.push_back(predict(req, rdy_exp));
            if (init_cnt < NUM_PTRS) begin
                init_cnt = init_cnt + 1;
            end
        end
        if (test_done) begin
            $display("test %s: %0d error(s), %s", test_name(test_id), test_errs,
                     (test_errs == 0) ? "clean" : "with errors");
            tests_run = tests_run + 1;
            if (test_errs != 0) begin
                tests_bad = tests_bad + 1;
            end
            test_errs = 0;
        end
        if (all_done) begin
            $display("tests run %0d, tests with errors %0d, errors %0d",
                     tests_run, tests_bad, errors);
        end
    end

endmodule : alloc_mon_check

`default_nettype wire

// ==== alloc_mon_tb.sv ====
// one request per cycle on the falling edge; the watchdog limit is derived from the test lengths.
`default_nettype none
`timescale 1ns/100ps

module alloc_mon_tb;
    import alloc_pkg::*;

    localparam int PERIOD_NS = 100;
    localparam int RST_CYC   = 16;
    localparam int RAND_REQS = 300;
    localparam int DRAIN_CYC = 5;  // mon latency, stats register and one spare.
    localparam int STIM_CYC  = 8 + NUM_PTRS + 1 + 4 + 4 + RAND_REQS;
    localparam int LIMIT_CYC = RST_CYC + NUM_PTRS + STIM_CYC + 6 * (DRAIN_CYC + 2) + 50;

    logic         from_tx;
    logic         rst;
    alloc_req_t   req;
    logic         ready;
    alloc_grant_t grant;
    alloc_mon_t   mon;
    alloc_stats_t stats;
    int           test_id;
    logic         test_done;
    logic         all_done;
    int           err_total;
    integer       seed;
    logic [31:0]  r;

    alloc_mon_top i_alloc_mon_top (
        .from_tx (from_tx),
        .rst     (rst),
        .req     (req),
        .ready   (ready),
        .grant   (grant),
        .mon     (mon),
        .stats   (stats)
    );

    alloc_mon_check i_alloc_mon_check (
        .from_tx   (from_tx),
        .rst       (rst),
        .req       (req),
        .ready     (ready),
        .grant     (grant),
        .mon       (mon),
        .stats     (stats),
        .test_id   (test_id),
        .test_done (test_done),
        .all_done  (all_done),
        .err_total (err_total)
    );

    initial begin
        from_tx = 1'b0;
        forever #(PERIOD_NS / 2) from_tx = ~from_tx;
    end

    task automatic drive(input logic a, input logic d, input logic [PTR_BITS-1:0] p);
        @(negedge from_tx);
        req.alloc   = a;
        req.dealloc = d;
        req.ptr     = p;
    endtask

    // let mon and stats settle before the test is closed.
    task automatic close_test();
        repeat (DRAIN_CYC) drive(1'b0, 1'b0, '0);
        @(negedge from_tx);
        test_done = 1'b1;
        @(negedge from_tx);
        test_done = 1'b0;
        test_id   = test_id + 1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        seed      = 10;
        rst       = 1'b1;
        req       = '0;
        test_id   = 1;
        test_done = 1'b0;
        all_done  = 1'b0;
        repeat (RST_CYC) @(negedge from_tx);
        rst = 1'b0;
        for (int i = 0; i < 8; i++) begin
            drive(~i[0], i[0] | i[1], PTR_BITS'(i));  // all land in the init sweep.
        end
        while (ready !== 1'b1) begin
            drive(1'b0, 1'b0, '0);
        end
        close_test();
        for (int i = 0; i < NUM_PTRS; i++) begin
            drive(1'b1, 1'b0, '0);
        end
        close_test();
        drive(1'b1, 1'b0, '0);  // pool is empty now.
        close_test();
        drive(1'b0, 1'b1, 32'd5);
        drive(1'b0, 1'b1, 32'd2);
        drive(1'b1, 1'b0, '0);
        drive(1'b1, 1'b0, '0);
        close_test();
        drive(1'b0, 1'b1, 32'd20);
        drive(1'b0, 1'b1, 32'd3);
        drive(1'b0, 1'b1, 32'd3);
        drive(1'b1, 1'b1, 32'd7);
        close_test();
        for (int i = 0; i < RAND_REQS; i++) begin
            r = $random(seed);
            drive(r[3:0] < 4'd8, r[3:0] >= 4'd7,
                  PTR_BITS'(r[7:4]) + ((r[11:8] == 4'd0) ? PTR_BITS'(16) : PTR_BITS'(0)));
        end
        close_test();
        @(negedge from_tx);
        all_done = 1'b1;
        @(negedge from_tx);
        all_done = 1'b0;
        if (err_total == 0 && i_alloc_mon_top.i_alloc_mon_checker.fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(LIMIT_CYC * PERIOD_NS);
        $display("watchdog: the tests did not finish within %0d cycles", LIMIT_CYC);
        $display("Something failed");
        $finish;
    end

endmodule : alloc_mon_tb

`default_nettype wire

// ==== alloc_mon_top.f ====
alloc_pkg.sv
alloc_ctrl_fsm.sv
ptr_free_list.sv
event_pipe.sv
mon_counters.sv
alloc_mon_top.sv
alloc_mon_checker.sv
alloc_mon_check.sv
alloc_mon_tb.sv

// ==== Makefile ====
# Verilator build and run for the pointer allocator testbench.

VERILATOR ?= verilator
TOP       ?= alloc_mon_tb
FLIST     ?= alloc_mon_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Something failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -q "Everything OK" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
